// ==== design/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data sram window
`define LSU_SRAM_BASE   (32'h8000_0000)
`define LSU_SRAM_WORDS  (1024)

// timer window, mtime low word at +0, high word at +4
`define LSU_CLINT_BASE  (32'h0200_0000)
`define LSU_CLINT_BYTES (8)

// cycles the sram holds ready low per request, 0 to 3
`define LSU_SRAM_WAIT   (1)

`endif

// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // access size, same encoding as the core's mask field
    typedef enum logic [1:0] {
        size_b = 2'b01,  // byte
        size_h = 2'b10,  // halfword
        size_w = 2'b11   // word
    } size_e;

    // slave selected by the address map
    typedef enum logic [1:0] {
        tgt_sram  = 2'd0,
        tgt_clint = 2'd1,
        tgt_none  = 2'd2  // unmapped
    } target_e;

    // one decoded access, 75 bits
    typedef struct packed {
        logic        we;          // store
        logic        sign;        // signed load
        size_e       size;
        logic [1:0]  offset;      // byte offset in word
        logic [29:0] word_addr;
        logic [3:0]  strb;
        logic [31:0] lane_wdata;  // store data in its byte lane
        target_e     target;
        logic        misaligned;
    } access_t;

endpackage

`default_nettype wire

// ==== design/lsu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lsu_bus_if;

    logic        valid;
    logic        ready;
    logic        we;
    logic [31:0] addr;   // byte address, word aligned
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        rvalid; // one cycle pulse
    logic [31:0] rdata;
    logic        err;

    modport master (
        output valid, we, addr, wdata, strb,
        input  ready, rvalid, rdata, err
    );

    modport slave (
        input  valid, we, addr, wdata, strb,
        output ready, rvalid, rdata, err
    );

endinterface

`default_nettype wire

// ==== design/lsu_access_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_access_decode (
    input  logic              req_we,
    input  logic              req_sign,
    input  lsu_pkg::size_e    req_size,
    input  logic [31:0]       req_addr,
    input  logic [31:0]       req_wdata,
    output lsu_pkg::access_t  acc
);

    localparam logic [31:0] sram_end  = `LSU_SRAM_BASE + 32'(4 * `LSU_SRAM_WORDS);
    localparam logic [31:0] clint_end = `LSU_CLINT_BASE + 32'(`LSU_CLINT_BYTES);

    logic in_sram;
    logic in_clint;

    assign in_sram  = (req_addr >= `LSU_SRAM_BASE) && (req_addr < sram_end);
    assign in_clint = (req_addr >= `LSU_CLINT_BASE) && (req_addr < clint_end);

    always_comb begin
        acc            = '0;
        acc.we         = req_we;
        acc.sign       = req_sign;
        acc.size       = req_size;
        acc.offset     = req_addr[1:0];
        acc.word_addr  = req_addr[31:2];
        acc.lane_wdata = req_wdata << {req_addr[1:0], 3'b000};

        case (req_size)
            lsu_pkg::size_b: begin
                acc.strb       = 4'b0001 << req_addr[1:0];
                acc.misaligned = 1'b0;
            end
            lsu_pkg::size_h: begin
                acc.strb       = req_addr[1] ? 4'b1100 : 4'b0011;
                acc.misaligned = req_addr[0]; // odd halfword
            end
            lsu_pkg::size_w: begin
                acc.strb       = 4'b1111;
                acc.misaligned = |req_addr[1:0];
            end
            default: begin
                acc.strb       = 4'b0000;
                acc.misaligned = 1'b1;        // no size, reject
            end
        endcase

        if (in_sram) begin
            acc.target = lsu_pkg::tgt_sram;
        end else if (in_clint) begin
            acc.target = lsu_pkg::tgt_clint;
        end else begin
            acc.target = lsu_pkg::tgt_none;
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_master (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  lsu_pkg::access_t  acc,
    output logic              req_ready,
    lsu_bus_if.master         sram,
    lsu_bus_if.master         clint,
    output logic              rsp_valid,
    output logic [31:0]       rsp_word,
    output logic              rsp_err,
    output lsu_pkg::access_t  rsp_acc
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_req  = 2'd1,
        st_wait = 2'd2,
        st_resp = 2'd3
    } state_e;

    state_e           state_q;
    lsu_pkg::access_t acc_q;
    logic [31:0]      word_q;
    logic             err_q;

    logic accept;
    logic acc_err;
    logic sel_sram;
    logic sel_ready;
    logic sel_rvalid;
    logic [31:0] sel_rdata;
    logic sel_err;

    assign req_ready = (state_q == st_idle);
    assign accept    = req_valid && req_ready;
    assign acc_err   = acc.misaligned || (acc.target == lsu_pkg::tgt_none);

    // response mux on the captured target
    assign sel_sram   = (acc_q.target == lsu_pkg::tgt_sram);
    assign sel_ready  = sel_sram ? sram.ready  : clint.ready;
    assign sel_rvalid = sel_sram ? sram.rvalid : clint.rvalid;
    assign sel_rdata  = sel_sram ? sram.rdata  : clint.rdata;
    assign sel_err    = sel_sram ? sram.err    : clint.err;

    // only the chosen bus sees valid
    assign sram.valid  = (state_q == st_req) && sel_sram;
    assign sram.we     = acc_q.we;
    assign sram.addr   = {acc_q.word_addr, 2'b00};
    assign sram.wdata  = acc_q.lane_wdata;
    assign sram.strb   = acc_q.strb;

    assign clint.valid = (state_q == st_req) && (acc_q.target == lsu_pkg::tgt_clint);
    assign clint.we    = acc_q.we;
    assign clint.addr  = {acc_q.word_addr, 2'b00};
    assign clint.wdata = acc_q.lane_wdata;
    assign clint.strb  = acc_q.strb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= acc_err ? st_resp : st_req; // errors skip the bus
                    end
                end
                st_req: begin
                    if (sel_ready) begin
                        state_q <= st_wait;
                    end
                end
                st_wait: begin
                    if (sel_rvalid) begin
                        state_q <= st_resp;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_q  <= acc;
            word_q <= '0;
            err_q  <= acc_err;
        end else if ((state_q == st_wait) && sel_rvalid) begin
            word_q <= sel_rdata;
            err_q  <= sel_err;
        end
    end

    assign rsp_valid = (state_q == st_resp);
    assign rsp_word  = word_q;
    assign rsp_err   = err_q;
    assign rsp_acc   = acc_q;

endmodule

`default_nettype wire

// ==== design/lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  logic [31:0]       word,
    input  lsu_pkg::access_t  acc,
    output logic [31:0]       load_data
);

    logic [31:0] shifted;

    assign shifted = word >> {acc.offset, 3'b000};

    always_comb begin
        if (acc.we) begin
            load_data = '0;  // stores return nothing
        end else begin
            case (acc.size)
                lsu_pkg::size_b: begin
                    load_data = {{24{acc.sign & shifted[7]}}, shifted[7:0]};
                end
                lsu_pkg::size_h: begin
                    load_data = {{16{acc.sign & shifted[15]}}, shifted[15:0]};
                end
                lsu_pkg::size_w: begin
                    load_data = shifted;
                end
                default: begin
                    load_data = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_sram (
    input  logic       clk,
    input  logic       rst_n,
    lsu_bus_if.slave   bus
);

    localparam int words       = `LSU_SRAM_WORDS;
    localparam int aw          = $clog2(words);
    localparam int wait_cycles = `LSU_SRAM_WAIT;
    localparam int cnt_w       = (wait_cycles > 1) ? $clog2(wait_cycles + 1) : 1;

    logic [31:0]      mem [words];
    logic [aw-1:0]    idx;
    logic [cnt_w-1:0] wait_cnt;
    logic             xfer;

    assign idx       = bus.addr[aw+1:2];
    assign bus.ready = (wait_cnt == cnt_w'(wait_cycles));
    assign xfer      = bus.valid && bus.ready;
    assign bus.err   = 1'b0;

    // wait counter restarts after every transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt   <= '0;
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= xfer;
            if (xfer) begin
                wait_cnt <= '0;
            end else if (bus.valid && !bus.ready) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.strb[i]) begin
                        mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                    end
                end
            end else begin
                bus.rdata <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_clint.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_clint (
    input  logic       clk,
    input  logic       rst_n,
    lsu_bus_if.slave   bus
);

    logic [63:0] mtime;
    logic        xfer;

    assign bus.ready = 1'b1;  // never stalls
    assign xfer      = bus.valid && bus.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime      <= '0;
            bus.rvalid <= 1'b0;
            bus.err    <= 1'b0;
        end else begin
            mtime      <= mtime + 64'd1;
            bus.rvalid <= xfer;
            if (xfer) begin
                bus.err <= bus.we;  // mtime is read-only here
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            if (bus.we) begin
                bus.rdata <= '0;
            end else begin
                bus.rdata <= bus.addr[2] ? mtime[63:32] : mtime[31:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_we,
    input  logic        req_sign,
    input  logic [1:0]  req_size,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    output logic        rsp_valid,
    output logic [31:0] rsp_rdata,
    output logic        rsp_err
);

    lsu_pkg::access_t acc;
    lsu_pkg::access_t rsp_acc;
    logic [31:0]      rsp_word;

    lsu_bus_if bus_sram ();
    lsu_bus_if bus_clint ();

    lsu_access_decode u_decode (
        .req_we    (req_we),
        .req_sign  (req_sign),
        .req_size  (lsu_pkg::size_e'(req_size)),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .acc       (acc)
    );

    lsu_bus_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .acc       (acc),
        .req_ready (req_ready),
        .sram      (bus_sram.master),
        .clint     (bus_clint.master),
        .rsp_valid (rsp_valid),
        .rsp_word  (rsp_word),
        .rsp_err   (rsp_err),
        .rsp_acc   (rsp_acc)
    );

    lsu_load_align u_align (
        .word      (rsp_word),
        .acc       (rsp_acc),
        .load_data (rsp_rdata)  // zero for stores and errors
    );

    lsu_sram u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus_sram.slave)
    );

    lsu_clint u_clint (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus_clint.slave)
    );

endmodule

`default_nettype wire

// ==== sim/lsu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_props (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic        rsp_valid,
    input  logic        sram_valid,
    input  logic        sram_ready,
    input  logic        sram_we,
    input  logic [31:0] sram_addr,
    input  logic [31:0] sram_wdata,
    input  logic [3:0]  sram_strb,
    input  logic        clint_valid,
    input  logic        clint_ready
);

    logic busy;  // request in flight

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end else if (rsp_valid) begin
            busy <= 1'b0;
        end
    end

    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !req_ready)
        else $error("req_ready high while a request is in flight");

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held longer than one cycle");

    a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> busy)
        else $error("rsp_valid without an accepted request");

    a_sram_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sram_valid && !sram_ready |=> sram_valid && $stable(sram_we) && $stable(sram_addr)
            && $stable(sram_wdata) && $stable(sram_strb))
        else $error("sram request dropped or changed before ready");

    // one transfer per request on the timer bus
    a_clint_once: assert property (@(posedge clk) disable iff (!rst_n)
        clint_valid && clint_ready |=> !clint_valid)
        else $error("timer valid still high after the transfer");

endmodule

bind lsu_top lsu_props props0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .sram_valid  (bus_sram.valid),
    .sram_ready  (bus_sram.ready),
    .sram_we     (bus_sram.we),
    .sram_addr   (bus_sram.addr),
    .sram_wdata  (bus_sram.wdata),
    .sram_strb   (bus_sram.strb),
    .clint_valid (bus_clint.valid),
    .clint_ready (bus_clint.ready)
);

`default_nettype wire

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    localparam int timeout_cycles = 50;
    localparam int sram_bytes     = 4 * `LSU_SRAM_WORDS;
    localparam int bw             = $clog2(sram_bytes);
    localparam int sram_lat       = 3 + `LSU_SRAM_WAIT;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_we;
    logic        req_sign;
    logic [1:0]  req_size;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        rsp_err;

    logic [7:0]  model [sram_bytes];  // byte image of the sram
    logic [31:0] got_data;
    logic        got_err;
    int          got_lat;

    always #4 clk = ~clk;

    lsu_top dut0 (.*);

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else
            stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int size_bytes(input logic [1:0] size);
        return (size == lsu_pkg::size_w) ? 4 : int'(size);
    endfunction

    function automatic logic [31:0] expect_load(input logic sign, input logic [1:0] size,
                                               input logic [31:0] addr);
        logic [bw-1:0] bi;
        logic [31:0]   val;
        int            nb;
        nb  = size_bytes(size);
        val = '0;
        for (int i = 0; i < nb; i++) begin
            bi = bw'(addr - `LSU_SRAM_BASE) + bw'(i);
            val[8*i +: 8] = model[bi];
        end
        if (sign && nb < 4 && val[8*nb-1]) begin
            val = val | (32'hffff_ffff << (8 * nb));  // sign fill
        end
        return val;
    endfunction

    // one request, returns data, error and cycles from acceptance to rsp_valid
    task automatic issue_request(input logic we, input logic sign, input logic [1:0] size,
                                 input logic [31:0] addr, input logic [31:0] wdata,
                                 output logic [31:0] rdata, output logic err, output int lat);
        int n;
        @(posedge clk);
        req_valid <= 1'b1;
        req_we    <= we;
        req_sign  <= sign;
        req_size  <= size;
        req_addr  <= addr;
        req_wdata <= wdata;
        n = 0;
        @(negedge clk);
        while (!req_ready) begin
            n++;
            if (n > timeout_cycles) begin
                stop_run("request was never accepted, req_ready stayed low");
            end
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > timeout_cycles) begin
                stop_run("no rsp_valid arrived for an accepted request");
            end
        end while (!rsp_valid);
        rdata = rsp_rdata;
        err   = rsp_err;
    endtask

    // sram or unmapped access, checked against the model
    task automatic run_access(input logic we, input logic sign, input logic [1:0] size,
                              input logic [31:0] addr, input logic [31:0] wdata);
        logic          bad;
        logic [31:0]   exp;
        logic [bw-1:0] bi;
        int            nb;
        nb  = size_bytes(size);
        bad = ((addr % nb) != 0) || ((addr - `LSU_SRAM_BASE) >= 32'(sram_bytes));
        exp = (we || bad) ? 32'h0 : expect_load(sign, size, addr);
        issue_request(we, sign, size, addr, wdata, got_data, got_err, got_lat);
        check_value(32'(got_err), 32'(bad), "rsp_err");
        check_value(got_data, exp, "rsp_rdata");
        check_value(got_lat, bad ? 1 : sram_lat, "response latency");
        if (we && !bad) begin
            for (int i = 0; i < nb; i++) begin
                bi = bw'(addr - `LSU_SRAM_BASE) + bw'(i);
                model[bi] = wdata[8*i +: 8];
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] t0;
        logic [1:0]  sz;
        logic [1:0]  off;
        void'($urandom(32'h125e_09fa));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_sign  = 1'b0;
        req_size  = lsu_pkg::size_w;
        req_addr  = '0;
        req_wdata = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int w = 0; w < 64; w++) begin  // test window, words 0..63
            a = `LSU_SRAM_BASE + 32'(4 * w);
            run_access(1'b1, 1'b0, lsu_pkg::size_w, a, fill_word(a));
        end

        for (int p = 0; p < 2; p++) begin
            for (int s = 1; s <= 3; s++) begin
                for (int o = 0; o < 4; o++) begin
                    if ((s == 2 && o % 2 != 0) || (s == 3 && o != 0)) begin
                        continue;
                    end
                    a = `LSU_SRAM_BASE + 32'h40 + 32'(o);
                    d = (p == 0) ? ($urandom & 32'h7f7f_7f7f) : ($urandom | 32'h8080_8080);
                    run_access(1'b1, 1'b0, 2'(s), a, d);
                    run_access(1'b0, 1'b1, 2'(s), a, 32'h0);
                    run_access(1'b0, 1'b0, 2'(s), a, 32'h0);
                end
            end
        end

        a = `LSU_SRAM_BASE + 32'h80;
        for (int o = 0; o < 4; o++) begin
            run_access(1'b1, 1'b0, lsu_pkg::size_b, a + 32'(o), $urandom);
            run_access(1'b0, 1'b0, lsu_pkg::size_w, a, 32'h0);  // other lanes kept
        end

        a = `LSU_SRAM_BASE + 32'hc0;
        run_access(1'b1, 1'b0, lsu_pkg::size_h, a + 32'd1, 32'hdead_beef);
        run_access(1'b1, 1'b0, lsu_pkg::size_w, a + 32'd2, 32'hcafe_f00d);
        run_access(1'b0, 1'b1, lsu_pkg::size_h, a + 32'd3, 32'h0);
        run_access(1'b0, 1'b0, lsu_pkg::size_w, a + 32'd1, 32'h0);
        run_access(1'b0, 1'b0, lsu_pkg::size_w, a, 32'h0);

        issue_request(1'b0, 1'b0, lsu_pkg::size_w, `LSU_CLINT_BASE, 32'h0,
                      got_data, got_err, got_lat);
        check_value(32'(got_err), 32'h0, "mtime low rsp_err");
        check_value(got_lat, 3, "timer latency");
        t0 = got_data;
        issue_request(1'b0, 1'b0, lsu_pkg::size_w, `LSU_CLINT_BASE, 32'h0,
                      got_data, got_err, got_lat);
        assert (got_data > t0) else
            stop_run($sformatf("error at %0t: mtime low %h not above %h", $time, got_data, t0));
        issue_request(1'b0, 1'b0, lsu_pkg::size_w, `LSU_CLINT_BASE + 32'd4, 32'h0,
                      got_data, got_err, got_lat);
        check_value(got_data, 32'h0, "mtime high word");
        issue_request(1'b1, 1'b0, lsu_pkg::size_w, `LSU_CLINT_BASE, 32'h1234_5678,
                      got_data, got_err, got_lat);
        check_value(32'(got_err), 32'h1, "timer write rsp_err");
        check_value(got_data, 32'h0, "timer write rsp_rdata");

        run_access(1'b0, 1'b0, lsu_pkg::size_w, 32'h1000_0000, 32'h0);
        run_access(1'b1, 1'b0, lsu_pkg::size_w, 32'h1000_0004, 32'h5555_aaaa);

        for (int n = 0; n < 300; n++) begin
            sz  = 2'($urandom_range(3, 1));
            off = 2'($urandom);
            if (sz == lsu_pkg::size_h) begin
                off[0] = 1'b0;
            end else if (sz == lsu_pkg::size_w) begin
                off = 2'b00;
            end
            a = `LSU_SRAM_BASE + {24'd0, 6'($urandom), off};
            run_access(1'($urandom), 1'($urandom), sz, a, $urandom);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/lsu_pkg.sv
design/lsu_bus_if.sv
design/lsu_access_decode.sv
design/lsu_bus_master.sv
design/lsu_load_align.sv
design/lsu_sram.sv
design/lsu_clint.sv
design/lsu_top.sv
sim/lsu_props.sv
sim/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= lsu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
